// ==== dv/rs_patterns.txt ====
# name nd pkt0 pkt1 cdb_tag0 cdb_tag1 cdb_valid resolve mispred fu_ready spots issue_valid out0 out1
# All hex; packet = {op[26:24] dest[23:18] src1[17:12] rdy1[11] src2[10:5] rdy2[4] b_mask[3:0]}
reset_idle      0 0000000 0000000 00 00 0 0 0 3 2 0 0000000 0000000
single_disp     1 0040810 0000000 00 00 0 0 0 3 2 0 0000000 0000000
single_issue    0 0000000 0000000 00 00 0 0 0 3 2 1 0040810 0000000
dual_disp       2 1080810 20C0810 00 00 0 0 0 3 2 0 0000000 0000000
dual_issue      0 0000000 0000000 00 00 0 0 0 3 2 3 1080810 20C0810
# Wakeup on both CDB lanes, one source at a time
wake_disp       1 3110220 0000000 00 00 0 0 0 3 2 0 0000000 0000000
wake_wait       0 0000000 0000000 00 00 0 0 0 3 2 0 0000000 0000000
wake_src2       0 0000000 0000000 00 11 2 0 0 3 2 0 0000000 0000000
wake_src1       0 0000000 0000000 10 00 1 0 0 3 2 0 0000000 0000000
wake_issue      0 0000000 0000000 00 00 0 0 0 3 2 1 3110A30 0000000
# Branch squash and correct resolve
squash_disp     2 0140811 4180812 00 00 0 0 0 0 2 0 0000000 0000000
squash_mispred  0 0000000 0000000 00 00 0 1 1 3 2 1 4180812 0000000
resolve_disp    1 11C0814 0000000 00 00 0 0 0 0 2 0 0000000 0000000
resolve_clear   0 0000000 0000000 00 00 0 4 0 0 2 0 0000000 0000000
resolve_keep    0 0000000 0000000 00 00 0 4 1 3 2 1 11C0810 0000000
# Back-pressure from the functional units
hold_disp       2 2200810 3240810 00 00 0 0 0 0 2 0 0000000 0000000
hold_busy       0 0000000 0000000 00 00 0 0 0 0 2 0 0000000 0000000
hold_busy       0 0000000 0000000 00 00 0 0 0 0 2 0 0000000 0000000
hold_port1      0 0000000 0000000 00 00 0 0 0 2 2 2 0000000 2200810
hold_release    0 0000000 0000000 00 00 0 0 0 3 2 1 3240810 0000000
# Fill the station with entries waiting on tag 20
full_fill       2 0420010 0460010 00 00 0 0 0 3 2 0 0000000 0000000
full_fill       2 04A0010 04E0010 00 00 0 0 0 3 2 0 0000000 0000000
full_fill       2 0520010 0560010 00 00 0 0 0 3 2 0 0000000 0000000
full_fill       2 05A0010 05E0018 00 00 0 0 0 3 2 0 0000000 0000000
full_station    0 0000000 0000000 00 00 0 0 0 3 0 0 0000000 0000000
full_squash     0 0000000 0000000 00 00 0 8 1 3 0 0 0000000 0000000
full_wake       0 0000000 0000000 20 00 1 0 0 3 1 0 0000000 0000000
full_issue      0 0000000 0000000 00 00 0 0 0 3 1 3 0420810 0460810
# Refill freed low slots while draining
reuse_disp      2 0600810 1640810 00 00 0 0 0 1 2 1 04A0810 0000000
reuse_issue     0 0000000 0000000 00 00 0 0 0 3 2 3 0600810 1640810
drain           0 0000000 0000000 00 00 0 0 0 3 2 3 04E0810 0520810
drain           0 0000000 0000000 00 00 0 0 0 3 2 3 0560810 05A0810
final_idle      0 0000000 0000000 00 00 0 0 0 3 2 0 0000000 0000000

// ==== dv/rs_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_settings.svh"

// Reservation station testbench
// Replays per-cycle stimulus from a pattern file and checks spots and issue
module rs_tb;

    import rs_pkg::*;

    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_FIELDS   = 14;   // Name plus thirteen hex columns

    logic                          clock;
    logic                          reset;
    logic [`NUM_SCALAR_BITS:0]     num_dispatched;
    rs_packet [`N-1:0]             rs_entries;
    logic [`NUM_SCALAR_BITS-1:0]   rs_spots;
    phys_reg_idx [`N-1:0]          cdb_tags;
    logic [`N-1:0]                 cdb_valid;
    b_mask_t                       b_mm_resolve;
    logic                          b_mm_mispred;
    logic [`N-1:0]                 fu_ready;
    logic [`N-1:0]                 issue_valid;
    rs_packet [`N-1:0]             issue_packets;

    // One queue per pattern column
    string                         pat_name[$];
    logic [`NUM_SCALAR_BITS:0]     pat_nd[$];
    rs_packet [`N-1:0]             pat_in[$];
    phys_reg_idx [`N-1:0]          pat_tags[$];
    logic [`N-1:0]                 pat_cdbv[$];
    b_mask_t                       pat_res[$];
    logic                          pat_mis[$];
    logic [`N-1:0]                 pat_fu[$];
    logic [`NUM_SCALAR_BITS-1:0]   pat_spots[$];
    logic [`N-1:0]                 pat_valid[$];
    rs_packet [`N-1:0]             pat_out[$];

    int                            errors;
    int                            checks;
    int                            num_patterns;
    logic                          patterns_loaded;

    rs_top uut (
        .clock         (clock),
        .reset         (reset),
        .num_dispatched(num_dispatched),
        .rs_entries    (rs_entries),
        .rs_spots      (rs_spots),
        .cdb_tags      (cdb_tags),
        .cdb_valid     (cdb_valid),
        .b_mm_resolve  (b_mm_resolve),
        .b_mm_mispred  (b_mm_mispred),
        .fu_ready      (fu_ready),
        .issue_valid   (issue_valid),
        .issue_packets (issue_packets)
    );

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic check_spots(input string name, input logic [`NUM_SCALAR_BITS-1:0] expected,
                               input logic [`NUM_SCALAR_BITS-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: rs_spots expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_valid(input string name, input logic [`N-1:0] expected,
                               input logic [`N-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: issue_valid expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_packet(input string name, input int port,
                                input rs_packet expected, input rs_packet actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: issue_packets[%0d] expected %h, actual %h",
                     name, port, expected, actual);
        end
    endtask

    // Lines starting with # and blank lines are skipped
    task automatic read_patterns();
        int                fd;
        int                code;
        string             line;
        string             name;
        logic [31:0]       nd, in0, in1, tag0, tag1, cv, res, mis, fu, spots, iv, out0, out1;
        rs_packet [`N-1:0] pkts;
        phys_reg_idx [`N-1:0] tags;
        fd = $fopen("dv/rs_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file dv/rs_patterns.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                           nd, in0, in1, tag0, tag1, cv, res, mis, fu, spots, iv, out0, out1);
            if (code != NUM_FIELDS) begin
                $display("Pattern line has %0d fields instead of %0d: %s",
                         code, NUM_FIELDS, line);
                errors++;
                continue;
            end
            pat_name.push_back(name);
            pat_nd.push_back(nd[`NUM_SCALAR_BITS:0]);
            pkts[0] = in0[$bits(rs_packet)-1:0];
            pkts[1] = in1[$bits(rs_packet)-1:0];
            pat_in.push_back(pkts);
            tags[0] = tag0[`PHYS_REG_BITS-1:0];
            tags[1] = tag1[`PHYS_REG_BITS-1:0];
            pat_tags.push_back(tags);
            pat_cdbv.push_back(cv[`N-1:0]);
            pat_res.push_back(res[`B_MASK_BITS-1:0]);
            pat_mis.push_back(mis[0]);
            pat_fu.push_back(fu[`N-1:0]);
            pat_spots.push_back(spots[`NUM_SCALAR_BITS-1:0]);
            pat_valid.push_back(iv[`N-1:0]);
            pkts[0] = out0[$bits(rs_packet)-1:0];
            pkts[1] = out1[$bits(rs_packet)-1:0];
            pat_out.push_back(pkts);
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(input int i);
        num_dispatched = pat_nd[i];
        rs_entries     = pat_in[i];
        cdb_tags       = pat_tags[i];
        cdb_valid      = pat_cdbv[i];
        b_mm_resolve   = pat_res[i];
        b_mm_mispred   = pat_mis[i];
        fu_ready       = pat_fu[i];
    endtask

    task automatic compare_outputs(input int i);
        check_spots(pat_name[i], pat_spots[i], rs_spots);
        check_valid(pat_name[i], pat_valid[i], issue_valid);
        for (int p = 0; p < `N; p++) begin
            if (pat_valid[i][p]) begin   // Idle ports carry no packet worth checking
                check_packet(pat_name[i], p, pat_out[i][p], issue_packets[p]);
            end
        end
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        patterns_loaded = 1'b0;
        reset           = 1'b1;
        num_dispatched  = '0;
        rs_entries      = '0;
        cdb_tags        = '0;
        cdb_valid       = '0;
        b_mm_resolve    = '0;
        b_mm_mispred    = 1'b0;
        fu_ready        = '0;

        read_patterns();
        num_patterns    = pat_name.size();
        patterns_loaded = 1'b1;
        if (num_patterns == 0) begin
            $display("No patterns were read, so nothing was tested");
            errors++;
        end

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        // Drive on the falling edge, compare 1 ns before the rising edge
        for (int i = 0; i < num_patterns; i++) begin
            drive_inputs(i);
            #1;
            compare_outputs(i);
            @(negedge clock);
        end

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog sized from the pattern count
    initial begin
        wait (patterns_loaded === 1'b1);
        #(CLOCK_PERIOD * (num_patterns + 20));
        $display("Timeout: the run was still going after %0d cycles",
                 num_patterns + 20);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/rs_pkg.sv
source/psel_gen.sv
source/rs.sv
source/issue_select.sv
source/rs_top.sv
dv/rs_tb.sv

// ==== source/issue_select.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_settings.svh"

// Issue selector
// Picks up to `N ready entries and steers them to the ports that accept work
module issue_select (
    input  rs_pkg::rs_packet [`RS_SZ-1:0] rs_data,
    input  logic [`RS_SZ-1:0]             rs_valid_next,
    input  logic [`N-1:0]                 fu_ready,
    output logic [`RS_SZ-1:0]             rs_data_issuing,
    output logic [`N-1:0]                 issue_valid,
    output rs_pkg::rs_packet [`N-1:0]     issue_packets
);

    logic [`RS_SZ-1:0]         ready_reqs;   // Valid with both operands ready
    logic [`N-1:0][`RS_SZ-1:0] ready_gnts;   // Ready entries, lowest index first
    logic [`N-1:0][`RS_SZ-1:0] port_gnt;     // Entry steered to each port

    always_comb begin
        for (int j = 0; j < `RS_SZ; j++) begin
            ready_reqs[j] = rs_valid_next[j]
                          & rs_data[j].source1_ready
                          & rs_data[j].source2_ready;
        end
    end

    psel_gen #(
        .WIDTH(`RS_SZ),
        .REQS (`N)
    ) issue_psel (
        .req    (ready_reqs),
        .gnt_bus(ready_gnts)
    );

    // Hand grants out to ready ports in port order
    // A busy port is skipped, so the next port gets the lower entry
    always_comb begin : steer
        int next_gnt;
        next_gnt = 0;
        port_gnt = '0;
        for (int p = 0; p < `N; p++) begin
            if (fu_ready[p]) begin
                port_gnt[p] = ready_gnts[next_gnt];
                next_gnt    = next_gnt + 1;
            end
        end
    end

    // Packet mux and the issued-entry vector back to the station
    always_comb begin
        rs_data_issuing = '0;
        issue_valid     = '0;
        issue_packets   = '0;
        for (int p = 0; p < `N; p++) begin
            issue_valid[p]  = |port_gnt[p];
            rs_data_issuing = rs_data_issuing | port_gnt[p];
            for (int j = 0; j < `RS_SZ; j++) begin
                if (port_gnt[p][j]) begin
                    issue_packets[p] = rs_data[j];  // Grant is one-hot
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/psel_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// Multi-grant priority selector
// Grant i goes to the i-th lowest set bit of req
module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    logic [WIDTH-1:0] remaining;  // Requests not yet granted

    always_comb begin
        remaining = req;
        for (int i = 0; i < REQS; i++) begin
            // Isolate the lowest set bit
            gnt_bus[i] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[i];
        end
    end

    // Grants must be single requested bits and never collide,
    // otherwise two slots or two ports would claim the same entry
    always_comb begin
        for (int i = 0; i < REQS; i++) begin
            assert final ($onehot0(gnt_bus[i]) && ((gnt_bus[i] & ~req) == '0))
                else $error("psel_gen: grant %0d is not a single requested bit", i);
            for (int k = i + 1; k < REQS; k++) begin
                assert final ((gnt_bus[i] & gnt_bus[k]) == '0)
                    else $error("psel_gen: grants %0d and %0d overlap", i, k);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/rs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_settings.svh"

// Reservation station storage
// Holds the entries, counts free slots, wakes sources from the CDB
// and applies branch resolve and squash
module rs (
    input  logic                                   clock,
    input  logic                                   reset,

    // Dispatch
    input  logic [`NUM_SCALAR_BITS:0]              num_dispatched,
    input  rs_pkg::rs_packet [`N-1:0]              rs_entries,
    output logic [`NUM_SCALAR_BITS-1:0]            rs_spots,

    // Common data bus
    input  rs_pkg::phys_reg_idx [`N-1:0]           cdb_tags,
    input  logic [`N-1:0]                          cdb_valid,

    // Issue
    input  logic [`RS_SZ-1:0]                      rs_data_issuing,
    output rs_pkg::rs_packet [`RS_SZ-1:0]          rs_data,
    output logic [`RS_SZ-1:0]                      rs_valid_next,

    // Branch stack
    input  rs_pkg::b_mask_t                        b_mm_resolve,
    input  logic                                   b_mm_mispred
);

    import rs_pkg::*;

    logic [`RS_SZ-1:0]               rs_valid;        // Registered occupancy
    logic [`RS_SZ-1:0]               free_slots;
    logic [`RS_NUM_ENTRIES_BITS-1:0] free_count;
    logic [`N-1:0][`RS_SZ-1:0]       dispatch_gnt;    // Slot picked for each dispatch lane
    logic [`RS_SZ-1:0]               dispatch_write;  // Slots written this cycle
    logic [`RS_SZ-1:0]               squash;
    b_mask_t                         clear_mask;

    // Only slots free at the start of the cycle take new work
    assign free_slots = ~rs_valid;

    psel_gen #(
        .WIDTH(`RS_SZ),
        .REQS (`N)
    ) dispatch_psel (
        .req    (free_slots),
        .gnt_bus(dispatch_gnt)
    );

    // Popcount of free slots
    always_comb begin
        free_count = '0;
        for (int j = 0; j < `RS_SZ; j++) begin
            free_count = free_count + `RS_NUM_ENTRIES_BITS'(free_slots[j]);
        end
    end

    // Dispatch never sees more than `N spots
    always_comb begin
        if (free_count > `RS_NUM_ENTRIES_BITS'(`N)) begin
            rs_spots = `NUM_SCALAR_BITS'(`N);
        end else begin
            rs_spots = free_count[`NUM_SCALAR_BITS-1:0];
        end
    end

    // Lanes beyond num_dispatched carry no packet
    always_comb begin
        dispatch_write = '0;
        for (int i = 0; i < `N; i++) begin
            if (i < num_dispatched) begin
                dispatch_write = dispatch_write | dispatch_gnt[i];
            end
        end
    end

    // Mispredict kills every entry that depends on the resolved branch
    always_comb begin
        for (int j = 0; j < `RS_SZ; j++) begin
            squash[j]        = b_mm_mispred & (|(rs_data[j].b_mask & b_mm_resolve));
            rs_valid_next[j] = rs_valid[j] & ~squash[j];
        end
    end

    // A correct resolve frees the branch bit everywhere
    assign clear_mask = b_mm_mispred ? '0 : b_mm_resolve;

    // Occupancy: drop issued and squashed entries, add dispatched ones
    always_ff @(posedge clock) begin
        if (reset) begin
            rs_valid <= '0;
        end else begin
            rs_valid <= (rs_valid_next & ~rs_data_issuing) | dispatch_write;
        end
    end

    // Entry payload, later assignments win
    always_ff @(posedge clock) begin
        for (int j = 0; j < `RS_SZ; j++) begin
            rs_data[j].b_mask <= rs_data[j].b_mask & ~clear_mask;
        end

        // CDB wakeup
        for (int c = 0; c < `N; c++) begin
            if (cdb_valid[c]) begin
                for (int j = 0; j < `RS_SZ; j++) begin
                    if (rs_data[j].source1 == cdb_tags[c]) begin
                        rs_data[j].source1_ready <= 1'b1;
                    end
                    if (rs_data[j].source2 == cdb_tags[c]) begin
                        rs_data[j].source2_ready <= 1'b1;
                    end
                end
            end
        end

        // New packets are stored as dispatch hands them over
        for (int i = 0; i < `N; i++) begin
            for (int j = 0; j < `RS_SZ; j++) begin
                if ((i < num_dispatched) && dispatch_gnt[i][j]) begin
                    rs_data[j] <= rs_entries[i];
                end
            end
        end
    end

    // Dispatch honours the credit count
    assert property (@(posedge clock) disable iff (reset)
        num_dispatched <= rs_spots)
        else $error("rs: dispatched %0d with only %0d spots", num_dispatched, rs_spots);

    // Issue may only pick live entries
    assert property (@(posedge clock) disable iff (reset)
        (rs_data_issuing & ~rs_valid_next) == '0)
        else $error("rs: issuing entries that are not valid");

endmodule

`default_nettype wire

// ==== source/rs_pkg.sv ====
`default_nettype none

`include "rs_settings.svh"

package rs_pkg;

    // Physical register tag
    typedef logic [`PHYS_REG_BITS-1:0] phys_reg_idx;

    // Branch dependency mask, one bit per unresolved branch
    typedef logic [`B_MASK_BITS-1:0] b_mask_t;

    // Functional-unit operation
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_mul = 3'd4
    } fu_op;

    // One station entry, as written by dispatch
    typedef struct packed {
        fu_op        op;
        phys_reg_idx dest;
        phys_reg_idx source1;
        logic        source1_ready;  // Operand already in the register file
        phys_reg_idx source2;
        logic        source2_ready;
        b_mask_t     b_mask;         // Branches this entry depends on
    } rs_packet;

endpackage

`default_nettype wire

// ==== source/rs_settings.svh ====
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Superscalar width, shared by dispatch, issue and the CDB
`define N 2

// Reservation station entries
`define RS_SZ 8

// Dispatch count is [`NUM_SCALAR_BITS:0], rs_spots one bit narrower
`define NUM_SCALAR_BITS 2

// Free-entry count, 0 up to `RS_SZ
`define RS_NUM_ENTRIES_BITS 4

`define PHYS_REG_BITS 6   // Physical register tag width
`define B_MASK_BITS 4     // One bit per in-flight branch

`endif

// ==== source/rs_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rs_settings.svh"

// Reservation station with its issue selector
module rs_top (
    input  logic                          clock,
    input  logic                          reset,

    // Dispatch
    input  logic [`NUM_SCALAR_BITS:0]     num_dispatched,
    input  rs_pkg::rs_packet [`N-1:0]     rs_entries,
    output logic [`NUM_SCALAR_BITS-1:0]   rs_spots,

    // Common data bus
    input  rs_pkg::phys_reg_idx [`N-1:0]  cdb_tags,
    input  logic [`N-1:0]                 cdb_valid,

    // Branch stack
    input  rs_pkg::b_mask_t               b_mm_resolve,
    input  logic                          b_mm_mispred,

    // Functional-unit ports
    input  logic [`N-1:0]                 fu_ready,
    output logic [`N-1:0]                 issue_valid,
    output rs_pkg::rs_packet [`N-1:0]     issue_packets
);

    import rs_pkg::*;

    rs_packet [`RS_SZ-1:0] rs_data;
    logic [`RS_SZ-1:0]     rs_valid_next;     // Valid after this cycle's squash
    logic [`RS_SZ-1:0]     rs_data_issuing;   // Entries leaving this cycle

    rs station (
        .clock          (clock),
        .reset          (reset),
        .num_dispatched (num_dispatched),
        .rs_entries     (rs_entries),
        .rs_spots       (rs_spots),
        .cdb_tags       (cdb_tags),
        .cdb_valid      (cdb_valid),
        .rs_data_issuing(rs_data_issuing),
        .rs_data        (rs_data),
        .rs_valid_next  (rs_valid_next),
        .b_mm_resolve   (b_mm_resolve),
        .b_mm_mispred   (b_mm_mispred)
    );

    issue_select selector (
        .rs_data        (rs_data),
        .rs_valid_next  (rs_valid_next),
        .fu_ready       (fu_ready),
        .rs_data_issuing(rs_data_issuing),
        .issue_valid    (issue_valid),
        .issue_packets  (issue_packets)
    );

endmodule

`default_nettype wire
